// ==== hdl/dehaze_img_pkg.sv ====
package dehaze_img_pkg;

    // 8x8 frame, one byte per channel
    localparam int IMG_DIM  = 8;
    localparam int PIX_W    = 8;
    localparam int ADDR_W   = 6;   // log2(IMG_DIM * IMG_DIM)
    localparam int WIN_SIZE = 9;   // 3x3 neighbourhood

    typedef logic [PIX_W-1:0] pix_t;

    // raster index and row/col view of the same address
    // row sits in the upper half so idx = row * IMG_DIM + col
    typedef union packed {
        logic [ADDR_W-1:0] idx;
        struct packed {
            logic [ADDR_W/2-1:0] row;
            logic [ADDR_W/2-1:0] col;
        } rc;
    } pix_addr_t;

    // window samples of one channel
    // [0] top left, [4] centre, [8] bottom right
    typedef pix_t [WIN_SIZE-1:0] win_t;

endpackage

// ==== hdl/dehaze_ctrl_pkg.sv ====
package dehaze_ctrl_pkg;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_SCAN = 2'd1,   // dark channel over interior
        ST_OUT  = 2'd2    // raster stream
    } scan_state_t;

    // interior bounds, same for rows and cols
    localparam logic [2:0] SCAN_FIRST = 3'd1;
    localparam logic [2:0] SCAN_LAST  = 3'd6;

    typedef logic [6:0] trans_t;   // percent, 0..100

    // t = T_MIN + dark * T_SPAN / 255, i.e. weight 0.75
    localparam trans_t T_MIN    = 7'd25;
    localparam trans_t T_SPAN   = 7'd75;
    localparam trans_t T_BORDER = 7'd100;

endpackage

// ==== hdl/scan_ctrl.sv ====
`timescale 1ns/10ps

module scan_ctrl
    import dehaze_img_pkg::*;
    import dehaze_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  logic      pixel_wr,
    output logic      mem_we,
    output logic      busy,
    output logic      scan_en,
    output pix_addr_t scan_pos,
    output logic      out_en,
    output pix_addr_t out_addr,
    output logic      last
);

    scan_state_t state;
    scan_state_t state_nxt;
    logic        scan_end;
    logic        out_end;

    assign scan_end = (scan_pos.rc.row == SCAN_LAST) && (scan_pos.rc.col == SCAN_LAST);
    assign out_end  = (out_addr.idx == ADDR_W'(IMG_DIM * IMG_DIM - 1));

    assign busy    = (state != ST_IDLE);
    assign mem_we  = pixel_wr && !busy;   // image frozen while processing
    assign scan_en = (state == ST_SCAN);
    assign out_en  = (state == ST_OUT);
    assign last    = out_en && out_end;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    state_nxt = ST_SCAN;
                end
            end
            ST_SCAN: begin
                if (scan_end) begin
                    state_nxt = ST_OUT;
                end
            end
            ST_OUT: begin
                if (out_end) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // both counters wrap back to their start value at the end of a pass
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scan_pos.rc.row <= SCAN_FIRST;
            scan_pos.rc.col <= SCAN_FIRST;
            out_addr.idx    <= '0;
        end else begin
            if (state == ST_SCAN) begin
                if (scan_pos.rc.col == SCAN_LAST) begin
                    scan_pos.rc.col <= SCAN_FIRST;
                    scan_pos.rc.row <= scan_end ? SCAN_FIRST : scan_pos.rc.row + 3'd1;
                end else begin
                    scan_pos.rc.col <= scan_pos.rc.col + 3'd1;
                end
            end
            if (state == ST_OUT) begin
                out_addr.idx <= out_addr.idx + 1'b1;   // 63 -> 0
            end
        end
    end

endmodule

// ==== hdl/pixel_mem.sv ====
`timescale 1ns/10ps

module pixel_mem
    import dehaze_img_pkg::*;
(
    input  logic      clk,
    input  logic      mem_we,
    input  pix_addr_t wr_addr,
    input  pix_t      wr_r,
    input  pix_t      wr_g,
    input  pix_t      wr_b,
    input  pix_addr_t scan_pos,
    input  pix_addr_t out_addr,
    output win_t      win_r,
    output win_t      win_g,
    output win_t      win_b,
    output pix_t      rd_r,
    output pix_t      rd_g,
    output pix_t      rd_b
);

    // one word per pixel, {r, g, b}
    logic [3*PIX_W-1:0] mem [IMG_DIM*IMG_DIM];
    pix_addr_t          win_addr [WIN_SIZE];

    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[wr_addr.idx] <= {wr_r, wr_g, wr_b};
        end
    end

    // neighbour k sits at row offset k/3 - 1 and col offset k%3 - 1
    // centre is always interior during the scan, so no edge clamp
    always_comb begin
        for (int k = 0; k < WIN_SIZE; k++) begin
            win_addr[k].rc.row = scan_pos.rc.row + 3'(k / 3) - 3'd1;
            win_addr[k].rc.col = scan_pos.rc.col + 3'(k % 3) - 3'd1;
            {win_r[k], win_g[k], win_b[k]} = mem[win_addr[k].idx];
        end
    end

    // raster read for the output pass
    assign {rd_r, rd_g, rd_b} = mem[out_addr.idx];

endmodule

// ==== hdl/dark_channel.sv ====
`timescale 1ns/10ps

module dark_channel
    import dehaze_img_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      scan_en,
    input  pix_addr_t scan_pos,
    input  win_t      win_r,
    input  win_t      win_g,
    input  win_t      win_b,
    input  pix_addr_t out_addr,
    output pix_t      dark_rd
);

    pix_t lvl0 [3*WIN_SIZE];   // all 27 samples
    pix_t lvl1 [WIN_SIZE];
    pix_t lvl2 [WIN_SIZE/3];
    pix_t win_min;
    pix_t dark_mem [IMG_DIM*IMG_DIM];

    function automatic pix_t min2(pix_t a, pix_t b);
        return (a < b) ? a : b;
    endfunction

    function automatic pix_t min3(pix_t a, pix_t b, pix_t c);
        return min2(min2(a, b), c);
    endfunction

    // ternary tree 27 -> 9 -> 3 -> 1
    always_comb begin
        for (int k = 0; k < WIN_SIZE; k++) begin
            lvl0[k]              = win_r[k];
            lvl0[WIN_SIZE + k]   = win_g[k];
            lvl0[2*WIN_SIZE + k] = win_b[k];
        end
        for (int i = 0; i < WIN_SIZE; i++) begin
            lvl1[i] = min3(lvl0[3*i], lvl0[3*i+1], lvl0[3*i+2]);
        end
        for (int i = 0; i < WIN_SIZE/3; i++) begin
            lvl2[i] = min3(lvl1[3*i], lvl1[3*i+1], lvl1[3*i+2]);
        end
        win_min = min3(lvl2[0], lvl2[1], lvl2[2]);
    end

    // border entries are never written and stay zero
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < IMG_DIM*IMG_DIM; i++) begin
                dark_mem[i] <= '0;
            end
        end else if (scan_en) begin
            dark_mem[scan_pos.idx] <= win_min;
        end
    end

    assign dark_rd = dark_mem[out_addr.idx];

endmodule

// ==== hdl/pixel_out.sv ====
`timescale 1ns/10ps

module pixel_out
    import dehaze_img_pkg::*;
    import dehaze_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      out_en,
    input  pix_addr_t out_addr,
    input  logic      last,
    input  pix_t      rd_r,
    input  pix_t      rd_g,
    input  pix_t      rd_b,
    input  pix_t      dark_rd,
    output logic      pixel_valid,
    output pix_t      pixel_r,
    output pix_t      pixel_g,
    output pix_t      pixel_b,
    output pix_t      dark,
    output trans_t    trans,
    output logic      done
);

    logic                            border;
    logic [PIX_W+$bits(trans_t)-1:0] prod;   // dark * 75, up to 19125
    trans_t                          trans_calc;

    assign border = (out_addr.rc.row == 3'd0) || (out_addr.rc.row == 3'(IMG_DIM - 1)) ||
                    (out_addr.rc.col == 3'd0) || (out_addr.rc.col == 3'(IMG_DIM - 1));

    assign prod       = dark_rd * T_SPAN;
    assign trans_calc = T_MIN + trans_t'(prod / {PIX_W{1'b1}});   // floor, /255

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pixel_valid <= 1'b0;
            done        <= 1'b0;
        end else begin
            pixel_valid <= out_en;
            done        <= last;
        end
    end

    always_ff @(posedge clk) begin
        if (out_en) begin
            pixel_r <= rd_r;
            pixel_g <= rd_g;
            pixel_b <= rd_b;
            dark    <= border ? '0 : dark_rd;
            trans   <= border ? T_BORDER : trans_calc;
        end
    end

endmodule

// ==== hdl/dehaze_top.sv ====
`timescale 1ns/10ps

module dehaze_top
    import dehaze_img_pkg::*;
    import dehaze_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      pixel_wr,
    input  pix_addr_t wr_addr,
    input  pix_t      wr_r,
    input  pix_t      wr_g,
    input  pix_t      wr_b,
    input  logic      start,
    output logic      busy,
    output logic      pixel_valid,
    output pix_t      pixel_r,
    output pix_t      pixel_g,
    output pix_t      pixel_b,
    output pix_t      dark,
    output trans_t    trans,
    output logic      done
);

    logic      mem_we;
    logic      scan_en;
    pix_addr_t scan_pos;
    logic      out_en;
    pix_addr_t out_addr;
    logic      last;
    win_t      win_r;
    win_t      win_g;
    win_t      win_b;
    pix_t      rd_r;
    pix_t      rd_g;
    pix_t      rd_b;
    pix_t      dark_rd;

    scan_ctrl scan_ctrl_i (
        .clk(clk), .rst(rst), .start(start), .pixel_wr(pixel_wr),
        .mem_we(mem_we), .busy(busy), .scan_en(scan_en), .scan_pos(scan_pos),
        .out_en(out_en), .out_addr(out_addr), .last(last)
    );

    pixel_mem pixel_mem_i (
        .clk(clk), .mem_we(mem_we), .wr_addr(wr_addr),
        .wr_r(wr_r), .wr_g(wr_g), .wr_b(wr_b),
        .scan_pos(scan_pos), .out_addr(out_addr),
        .win_r(win_r), .win_g(win_g), .win_b(win_b),
        .rd_r(rd_r), .rd_g(rd_g), .rd_b(rd_b)
    );

    dark_channel dark_channel_i (
        .clk(clk), .rst(rst), .scan_en(scan_en), .scan_pos(scan_pos),
        .win_r(win_r), .win_g(win_g), .win_b(win_b),
        .out_addr(out_addr), .dark_rd(dark_rd)
    );

    // registered stream, one cycle behind out_addr
    pixel_out pixel_out_i (
        .clk(clk), .rst(rst), .out_en(out_en), .out_addr(out_addr), .last(last),
        .rd_r(rd_r), .rd_g(rd_g), .rd_b(rd_b), .dark_rd(dark_rd),
        .pixel_valid(pixel_valid), .pixel_r(pixel_r), .pixel_g(pixel_g),
        .pixel_b(pixel_b), .dark(dark), .trans(trans), .done(done)
    );

endmodule

// ==== test/dehaze_assertions.sv ====
`timescale 1ns/10ps

module dehaze_assertions (
    input logic clk,
    input logic rst,
    input logic start,
    input logic busy,
    input logic pixel_valid,
    input logic done
);

    int fail_count = 0;   // failures seen so far

    // busy already dropped when the last pixel leaves
    done_with_valid: assert property (@(posedge clk) disable iff (rst)
        done |-> pixel_valid && !busy)
        else begin
            fail_count++;
            $error("done pulsed without pixel_valid or while busy");
        end

    valid_after_busy: assert property (@(posedge clk) disable iff (rst) pixel_valid |-> $past(busy))
        else begin
            fail_count++;
            $error("pixel_valid without busy in the cycle before");
        end

    // scan 36 + out 1 + register 1
    first_valid_delay: assert property (@(posedge clk) disable iff (rst)
        (start && !busy) |-> ##38 (pixel_valid && !$past(pixel_valid)))
        else begin
            fail_count++;
            $error("first pixel_valid not 38 cycles after start");
        end

    quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !busy && !pixel_valid && !done)
        else begin
            fail_count++;
            $error("outputs not low after reset");
        end

endmodule

bind dehaze_top dehaze_assertions dehaze_assertions_i (.*);

// ==== test/dehaze_tb.sv ====
`timescale 1ns/10ps

module dehaze_tb
    import dehaze_img_pkg::*;
    import dehaze_ctrl_pkg::*;
();

    localparam int NUM_FRAMES     = 3;
    localparam int NUM_PIX        = IMG_DIM * IMG_DIM;
    localparam int TIMEOUT_CYCLES = 1000;   // three frames take about 520

    logic      clk;
    logic      rst;
    logic      pixel_wr;
    pix_addr_t wr_addr;
    pix_t      wr_r;
    pix_t      wr_g;
    pix_t      wr_b;
    logic      start;
    logic      busy;
    logic      pixel_valid;
    pix_t      pixel_r;
    pix_t      pixel_g;
    pix_t      pixel_b;
    pix_t      dark;
    trans_t    trans;
    logic      done;

    // frame table of images and expected stream
    pix_t   img_r [NUM_FRAMES][NUM_PIX];
    pix_t   img_g [NUM_FRAMES][NUM_PIX];
    pix_t   img_b [NUM_FRAMES][NUM_PIX];
    int     exp_dark [NUM_FRAMES][NUM_PIX];
    int     exp_trans [NUM_FRAMES][NUM_PIX];
    integer seed = 32'h3caf;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;

    dehaze_top dehaze_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout: the DUT did not finish all frames within %0d cycles", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic check_cond(input bit ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("[ERROR] %0t: %s", $time, msg);
        end
    endtask

    function automatic int smaller(input int a, input int b);
        return (a < b) ? a : b;
    endfunction

    // frame 0 ramp, frame 1 grey noise, frame 2 colour noise with a black patch
    task automatic fill_frame(input int f);
        logic [31:0] v;
        for (int i = 0; i < NUM_PIX; i++) begin
            v = $random(seed);
            if (f == 0) begin
                v = {8'd0, {3{8'(255 - i)}}};
            end else if (f == 1) begin
                v[23:0] = {3{v[7:0]}};
            end else if ((i / IMG_DIM) inside {[4:6]} && (i % IMG_DIM) inside {[2:4]}) begin
                v = '0;
            end
            img_r[f][i] = v[23:16];
            img_g[f][i] = v[15:8];
            img_b[f][i] = v[7:0];
        end
    endtask

    task automatic build_expected(input int f);
        int m;
        int n;
        for (int p = 0; p < NUM_PIX; p++) begin
            if (p / IMG_DIM == 0 || p / IMG_DIM == IMG_DIM - 1 ||
                p % IMG_DIM == 0 || p % IMG_DIM == IMG_DIM - 1) begin
                exp_dark[f][p]  = 0;
                exp_trans[f][p] = 100;
            end else begin
                m = 255;
                for (int dr = -1; dr <= 1; dr++) begin
                    for (int dc = -1; dc <= 1; dc++) begin
                        n = p + dr * IMG_DIM + dc;
                        m = smaller(m, smaller(img_r[f][n], smaller(img_g[f][n], img_b[f][n])));
                    end
                end
                exp_dark[f][p]  = m;
                exp_trans[f][p] = 25 + (m * 75) / 255;
            end
        end
    endtask

    task automatic load_frame(input int f);
        for (int i = 0; i < NUM_PIX; i++) begin
            @(negedge clk);
            check_cond(!busy, $sformatf("frame %0d busy high while loading pixel %0d", f, i));
            @(posedge clk);
            pixel_wr    <= 1'b1;
            wr_addr.idx <= ADDR_W'(i);
            wr_r        <= img_r[f][i];
            wr_g        <= img_g[f][i];
            wr_b        <= img_b[f][i];
        end
        @(posedge clk);
        pixel_wr <= 1'b0;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // zeros into interior pixels and a second start that must all be ignored
    task automatic disturb_busy_frame();
        while (!busy) @(negedge clk);
        for (int k = 1; k <= 4; k++) begin
            @(posedge clk);
            pixel_wr    <= 1'b1;
            wr_addr.idx <= ADDR_W'(9 * k);
            wr_r        <= '0;
            wr_g        <= '0;
            wr_b        <= '0;
        end
        @(posedge clk);
        pixel_wr <= 1'b0;
        start    <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic collect_frame(input int f);
        int n;
        bit seen;
        bit finished;
        n = 0;
        seen = 1'b0;
        finished = 1'b0;
        while (!finished) begin
            @(negedge clk);
            if (pixel_valid && n < NUM_PIX) begin
                check_cond({pixel_r, pixel_g, pixel_b} == {img_r[f][n], img_g[f][n], img_b[f][n]},
                    $sformatf("frame %0d pixel %0d rgb %h%h%h expected %h%h%h", f, n, pixel_r,
                    pixel_g, pixel_b, img_r[f][n], img_g[f][n], img_b[f][n]));
                check_cond(int'(dark) == exp_dark[f][n],
                    $sformatf("frame %0d pixel %0d dark %0d expected %0d",
                    f, n, dark, exp_dark[f][n]));
                check_cond(int'(trans) == exp_trans[f][n],
                    $sformatf("frame %0d pixel %0d trans %0d expected %0d",
                    f, n, trans, exp_trans[f][n]));
                n++;
                seen = 1'b1;
            end else begin
                check_cond(!seen, $sformatf("frame %0d stream broken after %0d pixels", f, n));
            end
            if (done) begin
                check_cond(n == NUM_PIX && pixel_valid && !busy,
                    $sformatf("frame %0d done after %0d pixels, busy %b", f, n, busy));
                finished = 1'b1;
            end
        end
    endtask

    initial begin
        rst         <= 1'b1;
        pixel_wr    <= 1'b0;
        wr_addr.idx <= '0;
        wr_r        <= '0;
        wr_g        <= '0;
        wr_b        <= '0;
        start       <= 1'b0;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            fill_frame(f);
            build_expected(f);
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            load_frame(f);
            pulse_start();
            if (f == 1) begin
                disturb_busy_frame();
            end
            collect_frame(f);
        end
        repeat (3) @(posedge clk);
        $display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
            dehaze_top_i.dehaze_assertions_i.fail_count);
        if (errors == 0 && dehaze_top_i.dehaze_assertions_i.fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== dehaze.f ====
hdl/dehaze_img_pkg.sv
hdl/dehaze_ctrl_pkg.sv
hdl/scan_ctrl.sv
hdl/pixel_mem.sv
hdl/dark_channel.sv
hdl/pixel_out.sv
hdl/dehaze_top.sv
test/dehaze_assertions.sv
test/dehaze_tb.sv

// ==== Makefile ====
SRCS := $(filter-out +%,$(shell cat dehaze.f))

.PHONY: all run clean

all: run

obj_dir/Vdehaze_tb: dehaze.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module dehaze_tb -f dehaze.f

run: obj_dir/Vdehaze_tb
	./obj_dir/Vdehaze_tb +verilator+error+limit+1000 | tee sim.log
	@if grep -q "Verification failed" sim.log; then exit 1; fi
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
